//--- sms_cfg_pkg.sv
// Widths, counts and clock-enable phase constants of the support logic
package sms_cfg_pkg;

	// ==================================================
	// Address widths
	// ==================================================
	localparam int ROM_ADDR_W   = 22;               // Cartridge ROM, 4 MB max
	localparam int DL_ADDR_W    = 25;               // Host download byte address
	localparam int HEADER_BYTES = 512;              // Optional copier header

	// ==================================================
	// Clock-enable divider
	// ==================================================
	localparam int CE_PERIOD = 30;
	localparam int CE_CNT_W  = $clog2(CE_PERIOD);

	// One bit per counter value, bit n set means the strobe fires at n
	localparam logic [CE_PERIOD-1:0] CE_CPU_PHASES = (30'd1 << 9) | (30'd1 << 24);
	localparam logic [CE_PERIOD-1:0] CE_VDP_PHASES = (30'd1 << 4) | (30'd1 << 9) |
		(30'd1 << 14) | (30'd1 << 19) | (30'd1 << 24) | (30'd1 << 29);
	localparam logic [CE_PERIOD-1:0] CE_PIX_PHASES = (30'd1 << 9) | (30'd1 << 19) |
		(30'd1 << 29);

	// ==================================================
	// Backup image and download indices
	// ==================================================
	localparam int SECTOR_BITS = 6;                 // 64 sectors of 512 bytes

	localparam logic [7:0] CODE_INDEX = 8'hff;      // Cheat file
	localparam logic [4:0] GG_INDEX   = 5'd2;       // Handheld cartridge slot

endpackage

//--- sms_types_pkg.sv
// Backup state and download kind enums, cheat record struct
package sms_types_pkg;

	// ==================================================
	// Enumerations
	// ==================================================
	typedef enum logic [1:0] {
		BK_IDLE    = 2'd0,
		BK_LOADING = 2'd1,
		BK_SAVING  = 2'd2
	} bk_state_e;

	// What the host is currently sending
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_CART = 2'd1,
		DL_CODE = 2'd2
	} dl_kind_e;

	// ==================================================
	// Cheat record
	// ==================================================
	// Flags sit in the top word, replace value in the bottom one
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

//--- dl_if.sv
// Host download bus interface with host and loader modports
interface dl_if;
	import sms_cfg_pkg::*;
	import sms_types_pkg::*;

	logic                 download;
	logic [7:0]           index;
	logic                 wr;             // One byte per strobe
	logic [DL_ADDR_W-1:0] addr;
	logic [7:0]           dout;
	dl_kind_e             kind;

	// All ones on the index marks a cheat file
	assign kind = !download ? DL_NONE :
		(index == CODE_INDEX) ? DL_CODE : DL_CART;

	modport host   (output download, index, wr, addr, dout, input kind);
	modport loader (input download, index, wr, addr, dout, kind);

endinterface

//--- ce_gen.sv
// Master divider producing the CPU, VDP, pixel and sprite clock enables
module ce_gen (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import sms_cfg_pkg::*;

	logic [CE_CNT_W-1:0] cnt;

	// Counter wraps every CE_PERIOD clocks
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CE_CNT_W'(CE_PERIOD - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Strobes lag the counter by one clock
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			ce_cpu <= CE_CPU_PHASES[cnt];  // div15
			ce_vdp <= CE_VDP_PHASES[cnt];  // div5
			ce_pix <= CE_PIX_PHASES[cnt];  // div10
			ce_sp  <= cnt[0];              // div2
		end
	end

	// CPU phases are a subset of the VDP phases
	a_cpu_with_vdp : assert property (
		@(posedge clk_sys) disable iff (!rst_n) ce_cpu |-> ce_vdp
	) else $error("ce_cpu fired without ce_vdp");

endmodule

//--- cart_loader.sv
// Cartridge ROM write handshake, size mask learning and ROM read mapping
module cart_loader #(
	parameter int ROM_ADDR_W = sms_cfg_pkg::ROM_ADDR_W
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	dl_if.loader                  dl,
	output logic                  dl_wait,
	output logic                  rom_wr_req,
	input  logic                  rom_wr_ack,
	output logic [ROM_ADDR_W-1:0] rom_wr_addr,
	output logic [7:0]            rom_wr_data,
	input  logic [ROM_ADDR_W-1:0] cpu_rom_addr,
	output logic [ROM_ADDR_W-1:0] rom_raddr,
	output logic                  gg_mode,
	output logic                  cart_done
);
	import sms_cfg_pkg::*;
	import sms_types_pkg::*;

	logic                  cart_dl;
	logic                  old_cart;
	logic                  cart_start;
	logic                  cart_wr;
	logic [ROM_ADDR_W-1:0] dl_rom_addr;
	logic [ROM_ADDR_W-1:0] cart_mask;
	logic [ROM_ADDR_W-1:0] cart_mask512;    // Mask for images with a header
	logic                  cart_sz512;

	assign cart_dl     = dl.kind == DL_CART;
	assign cart_wr     = dl.wr && cart_dl;
	assign cart_start  = cart_dl && !old_cart;
	assign cart_done   = old_cart && !cart_dl;
	assign dl_rom_addr = dl.addr[ROM_ADDR_W-1:0];

	// ==================================================
	// Toggle handshake toward the ROM storage
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_cart    <= 1'b0;
			dl_wait     <= 1'b0;
			rom_wr_req  <= 1'b0;
			rom_wr_addr <= '0;
		end else begin
			old_cart <= cart_dl;
			if (cart_wr) begin
				dl_wait    <= 1'b1;              // Hold the host off
				rom_wr_req <= ~rom_wr_req;
			end else if (dl_wait && (rom_wr_req == rom_wr_ack)) begin
				dl_wait     <= 1'b0;
				rom_wr_addr <= rom_wr_addr + 1'b1;
			end
			if (cart_start)
				rom_wr_addr <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			rom_wr_data <= dl.dout;
	end

	// ==================================================
	// Image size learning
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_sz512 <= 1'b0;
			gg_mode    <= 1'b0;
		end else begin
			if (cart_wr)
				gg_mode <= dl.index[4:0] == GG_INDEX;
			// A header leaves the last address 512 past a power of two
			if (cart_done)
				cart_sz512 <= dl.addr[9];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			cart_mask    <= cart_mask | dl_rom_addr;
			cart_mask512 <= cart_mask512 | (dl_rom_addr - ROM_ADDR_W'(HEADER_BYTES));
			if (dl_rom_addr == '0)
				cart_mask <= '0;
			if (dl_rom_addr == ROM_ADDR_W'(HEADER_BYTES))
				cart_mask512 <= '0;
		end
	end

	// CPU reads skip the header and wrap at the image size
	always_ff @(posedge clk_sys) begin
		if (cart_sz512)
			rom_raddr <= (cpu_rom_addr + ROM_ADDR_W'(HEADER_BYTES)) & cart_mask512;
		else
			rom_raddr <= cpu_rom_addr & cart_mask;
	end

	a_no_wr_while_wait : assert property (
		@(posedge clk_sys) disable iff (!rst_n) dl_wait |-> !cart_wr
	) else $error("Host wrote a cartridge byte while dl_wait was high");

endmodule

//--- cheat_loader.sv
// Collector of sixteen downloaded bytes into one cheat record
module cheat_loader (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	dl_if.loader                      dl,
	output logic                      code_valid,
	output sms_types_pkg::cheat_code_t code
);
	import sms_types_pkg::*;

	logic       code_wr;
	logic [1:0] field_sel;
	logic [4:0] byte_lsb;                 // Bit offset of the byte in its field

	assign code_wr   = dl.wr && (dl.kind == DL_CODE);
	assign field_sel = dl.addr[3:2];
	assign byte_lsb  = {dl.addr[1:0], 3'b000};

	// Last byte of the record announces it
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (dl.addr[3:0] == 4'd15);
	end

	// ==================================================
	// Byte placement, least significant byte first
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (field_sel)
				2'd0: begin
					if (dl.addr[1:0] == 2'd3)
						code.flags[31:16] <= {2{dl.dout}};  // Top flags byte doubled
					else
						code.flags[byte_lsb +: 8] <= dl.dout;
				end
				2'd1: code.address[byte_lsb +: 8] <= dl.dout;
				2'd2: code.compare[byte_lsb +: 8] <= dl.dout;
				default: code.replace[byte_lsb +: 8] <= dl.dout;
			endcase
		end
	end

endmodule

//--- backup_sync.sv
// Save-image enable, pending-write flag and backup sector load/save sequencer
module backup_sync #(
	parameter int SECTOR_BITS = sms_cfg_pkg::SECTOR_BITS
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	dl_if.loader                   dl,
	input  logic                   cart_done,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_size_nz,
	input  logic                   bk_load,
	input  logic                   bk_save,
	input  logic                   autosave,
	input  logic                   osd_open,
	input  logic                   nvram_we,
	output logic [SECTOR_BITS-1:0] sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	input  logic                   sd_ack,
	output logic                   bk_busy,
	output logic                   bk_loading
);
	import sms_types_pkg::*;

	bk_state_e state;
	logic      cart_dl;
	logic      old_cart_dl;
	logic      bk_ena;
	logic      bk_pending;
	logic      save_req;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_start;
	logic      save_start;
	logic      ack_fall;

	assign cart_dl    = dl.kind == DL_CART;
	assign bk_busy    = state != BK_IDLE;
	assign bk_loading = state == BK_LOADING;

	// Autosave fires when the menu opens with unsaved writes
	assign save_req   = bk_save || (autosave && bk_pending && osd_open);
	assign load_start = (bk_load && bk_ena && !old_load) ||
		(cart_done && img_size_nz && bk_ena);
	assign save_start = save_req && bk_ena && !old_save;
	assign ack_fall   = old_ack && !sd_ack;

	// ==================================================
	// Enable and pending tracking
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_cart_dl <= 1'b0;
			bk_ena      <= 1'b0;
			bk_pending  <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			if (cart_dl && !old_cart_dl)
				bk_ena <= 1'b0;
			// Image is mounted by the time the cartridge arrives
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state    <= BK_IDLE;
			sd_lba   <= '0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load && bk_ena;
			old_save <= save_req && bk_ena;
			old_ack  <= sd_ack;

			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;                      // Request taken
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_start) begin
						state  <= BK_LOADING;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
					end else if (save_start) begin
						state  <= BK_SAVING;
						sd_lba <= '0;
						sd_wr  <= 1'b1;
					end
				end
				default: begin
					if (ack_fall) begin
						if (&sd_lba) begin
							state <= BK_IDLE;           // Last sector done
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= state == BK_LOADING;
							sd_wr  <= state == BK_SAVING;
						end
					end
				end
			endcase
		end
	end

	a_rd_wr_excl : assert property (
		@(posedge clk_sys) disable iff (!rst_n) !(sd_rd && sd_wr)
	) else $error("sd_rd and sd_wr high together");

endmodule

//--- sms_support.sv
// Top level of the cartridge support logic, wiring the four blocks to plain ports
module sms_support #(
	parameter int ROM_ADDR_W  = sms_cfg_pkg::ROM_ADDR_W,
	parameter int SECTOR_BITS = sms_cfg_pkg::SECTOR_BITS
) (
	input  logic                              clk_sys,
	input  logic                              rst_n,
	// Host download bus
	input  logic                              dl_download,
	input  logic                              dl_wr,
	input  logic [7:0]                        dl_index,
	input  logic [sms_cfg_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]                        dl_dout,
	output logic                              dl_wait,
	// ROM storage
	output logic                              rom_wr_req,
	input  logic                              rom_wr_ack,
	output logic [ROM_ADDR_W-1:0]             rom_wr_addr,
	output logic [7:0]                        rom_wr_data,
	input  logic [ROM_ADDR_W-1:0]             cpu_rom_addr,
	output logic [ROM_ADDR_W-1:0]             rom_raddr,
	output logic                              gg_mode,
	// Clock enables
	output logic                              ce_cpu,
	output logic                              ce_vdp,
	output logic                              ce_pix,
	output logic                              ce_sp,
	// Cheats
	output logic                              code_valid,
	output sms_types_pkg::cheat_code_t        code,
	// Backup RAM image
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic                              img_size_nz,
	input  logic                              bk_load,
	input  logic                              bk_save,
	input  logic                              autosave,
	input  logic                              osd_open,
	input  logic                              nvram_we,
	output logic [SECTOR_BITS-1:0]            sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	input  logic                              sd_ack,
	output logic                              bk_busy,
	output logic                              bk_loading
);

	logic cart_done;

	dl_if dl ();

	assign dl.download = dl_download;
	assign dl.wr       = dl_wr;
	assign dl.index    = dl_index;
	assign dl.addr     = dl_addr;
	assign dl.dout     = dl_dout;

	ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader #(.ROM_ADDR_W(ROM_ADDR_W)) u_cart_loader (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl.loader),
		.dl_wait      (dl_wait),
		.rom_wr_req   (rom_wr_req),
		.rom_wr_ack   (rom_wr_ack),
		.rom_wr_addr  (rom_wr_addr),
		.rom_wr_data  (rom_wr_data),
		.cpu_rom_addr (cpu_rom_addr),
		.rom_raddr    (rom_raddr),
		.gg_mode      (gg_mode),
		.cart_done    (cart_done)
	);

	cheat_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl.loader),
		.code_valid (code_valid),
		.code       (code)
	);

	backup_sync #(.SECTOR_BITS(SECTOR_BITS)) u_backup_sync (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl.loader),
		.cart_done    (cart_done),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.nvram_we     (nvram_we),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

//--- tb_sms_support.sv
// Testbench with stimulus tables, ROM and SD models, checks, timeout and summary
module tb_sms_support;
	import sms_cfg_pkg::*;
	import sms_types_pkg::*;

	localparam int N_CARTS         = 4;
	localparam int N_READS         = 6;
	localparam int N_CODES         = 2;
	localparam int N_SECTORS       = 1 << SECTOR_BITS;
	localparam int LOAD_CART_BYTES = 256;
	localparam int MAX_ROM_DELAY   = 5;   // Extra clocks before the ROM acknowledges
	localparam int MAX_SD_DELAY    = 3;
	localparam int MAX_SD_HOLD     = 8;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  dl_download;
	logic                  dl_wr;
	logic [7:0]            dl_index;
	logic [DL_ADDR_W-1:0]  dl_addr;
	logic [7:0]            dl_dout;
	logic                  dl_wait;
	logic                  rom_wr_req;
	logic                  rom_wr_ack;
	logic [ROM_ADDR_W-1:0] rom_wr_addr;
	logic [7:0]            rom_wr_data;
	logic [ROM_ADDR_W-1:0] cpu_rom_addr;
	logic [ROM_ADDR_W-1:0] rom_raddr;
	logic                  gg_mode;
	logic                  ce_cpu;
	logic                  ce_vdp;
	logic                  ce_pix;
	logic                  ce_sp;
	logic                  code_valid;
	cheat_code_t           code;
	logic                  img_mounted;
	logic                  img_readonly;
	logic                  img_size_nz;
	logic                  bk_load;
	logic                  bk_save;
	logic                  autosave;
	logic                  osd_open;
	logic                  nvram_we;
	logic [SECTOR_BITS-1:0] sd_lba;
	logic                  sd_rd;
	logic                  sd_wr;
	logic                  sd_ack;
	logic                  bk_busy;
	logic                  bk_loading;

	// ==================================================
	// Stimulus tables
	// ==================================================
	int         cart_size  [N_CARTS] = '{1024, 1536, 2048, 2560};
	bit         cart_hdr   [N_CARTS] = '{1'b0, 1'b1, 1'b0, 1'b1};   // 512-byte copier header
	logic [7:0] cart_index [N_CARTS] = '{8'h00, 8'h01, 8'h02, 8'h42};
	bit         cart_gg    [N_CARTS] = '{1'b0, 1'b0, 1'b1, 1'b1};   // Handheld slot selected

	logic [ROM_ADDR_W-1:0] cpu_addrs [N_READS] = '{22'h000000, 22'h0001ff, 22'h000200,
		22'h0007ff, 22'h012345, 22'h3ffe00};

	// Sixteen bytes per record, in download order
	logic [7:0] cheat_bytes [N_CODES][16] = '{
		'{8'h01, 8'h00, 8'h00, 8'h00, 8'h34, 8'h12, 8'h00, 8'h00,
		  8'haa, 8'h00, 8'h00, 8'h00, 8'h55, 8'h00, 8'h00, 8'h00},
		'{8'h11, 8'h22, 8'h33, 8'h44, 8'h78, 8'h56, 8'h34, 8'h12,
		  8'hde, 8'hbc, 8'h9a, 8'h78, 8'h10, 8'h32, 8'h54, 8'h76}
	};
	// Flags, address, compare, replace; byte 3 covers the whole top half of the flags
	logic [127:0] cheat_expect [N_CODES] = '{
		128'h00000001_00001234_000000aa_00000055,
		128'h44442211_12345678_789abcde_76543210
	};

	logic [ROM_ADDR_W-1:0]  rom_addr_q [$];
	logic [7:0]             rom_data_q [$];
	logic [SECTOR_BITS-1:0] sd_lba_q [$];
	logic [1:0]             sd_kind_q [$];   // {sd_rd, sd_wr} per sector

	integer seed = 32'h52c236dc;
	int     errors;
	int     test_err_start;
	int     tests_run;
	int     tests_failed;
	int     cycle_count;
	int     timeout_limit;
	int     valid_count;
	bit     ce_window;
	int     n_cpu;
	int     n_vdp;
	int     n_pix;
	int     n_sp;
	logic   gg_expect;

	sms_support sms_support_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic report_mismatch(input string sig, input logic [127:0] got,
		input logic [127:0] exp);
		$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - test_err_start;
		tests_run++;
		if (n == 0) begin
			$display("test %s ... ok", name);
		end else begin
			$display("test %s ... %0d errors", name, n);
			tests_failed++;
		end
		test_err_start = errors;
	endtask

	// Fill byte depends on every address bit
	function automatic logic [7:0] byte_at(input logic [DL_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'h2d, a[24]};
	endfunction

	function automatic logic [ROM_ADDR_W-1:0] expected_raddr(input logic [ROM_ADDR_W-1:0] cpu,
		input int size, input bit hdr);
		logic [ROM_ADDR_W-1:0] offset;
		logic [ROM_ADDR_W-1:0] mask;
		offset = hdr ? ROM_ADDR_W'(HEADER_BYTES) : '0;
		mask   = ROM_ADDR_W'(size) - offset - 1'b1;   // Payload size minus one
		return (cpu + offset) & mask;
	endfunction

	// One strobe, then hold off while the ROM write is pending
	task automatic send_byte(input logic [DL_ADDR_W-1:0] a, input logic [7:0] d);
		dl_addr = a;
		dl_dout = d;
		dl_wr   = 1'b1;
		idle_cycles(1);
		dl_wr   = 1'b0;
		while (dl_wait)
			idle_cycles(1);
	endtask

	task automatic download_cart(input logic [7:0] idx, input int size);
		rom_addr_q.delete();
		rom_data_q.delete();
		dl_index    = idx;
		dl_download = 1'b1;
		idle_cycles(1);
		for (int i = 0; i < size; i++)
			send_byte(DL_ADDR_W'(i), byte_at(DL_ADDR_W'(i)));
		dl_addr = DL_ADDR_W'(size);        // Host address ends past the last byte
		idle_cycles(1);
		dl_download = 1'b0;
		idle_cycles(2);
	endtask

	task automatic check_sectors(input logic [1:0] kind);
		if (sd_lba_q.size() != N_SECTORS) begin
			report_error($sformatf("%0d sectors transferred instead of %0d",
				sd_lba_q.size(), N_SECTORS));
		end else begin
			for (int i = 0; i < N_SECTORS; i++) begin
				if (sd_lba_q[i] !== SECTOR_BITS'(i))
					report_mismatch("sd_lba", sd_lba_q[i], i);
				if (sd_kind_q[i] !== kind)
					report_mismatch("{sd_rd,sd_wr}", sd_kind_q[i], kind);
			end
		end
	endtask

	// ==================================================
	// ROM storage and SD card models
	// ==================================================
	initial begin : rom_model
		int delay;
		rom_wr_ack = 1'b0;
		forever begin
			idle_cycles(1);
			if (rst_n && (rom_wr_req !== rom_wr_ack)) begin
				delay = $unsigned($random(seed)) % (MAX_ROM_DELAY + 1);
				idle_cycles(delay);
				rom_addr_q.push_back(rom_wr_addr);
				rom_data_q.push_back(rom_wr_data);
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	initial begin : sd_model
		int delay;
		sd_ack = 1'b0;
		forever begin
			idle_cycles(1);
			if (sd_rd || sd_wr) begin
				sd_lba_q.push_back(sd_lba);
				sd_kind_q.push_back({sd_rd, sd_wr});
				delay = $unsigned($random(seed)) % (MAX_SD_DELAY + 1);
				idle_cycles(delay);
				sd_ack = 1'b1;
				delay = 1 + $unsigned($random(seed)) % MAX_SD_HOLD;
				idle_cycles(delay);
				sd_ack = 1'b0;                 // Sector ends here
			end
		end
	end

	// Monitors sample at the falling edge, away from register updates
	always @(negedge clk_sys) begin
		if (ce_window) begin
			n_cpu += int'(ce_cpu);
			n_vdp += int'(ce_vdp);
			n_pix += int'(ce_pix);
			n_sp  += int'(ce_sp);
			if (ce_cpu && !ce_vdp)
				report_error("ce_cpu pulsed without ce_vdp");
		end
		if (code_valid)
			valid_count++;
		if (rst_n && (rom_wr_req !== rom_wr_ack) && !dl_wait)
			report_error("dl_wait low while a ROM write is outstanding");
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("ERROR t=%0t run did not finish within %0d cycles", $time, timeout_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin : main
		int total_bytes;
		int waited;
		rst_n        = 1'b0;
		dl_download  = 1'b0;
		dl_wr        = 1'b0;
		dl_index     = 8'h00;
		dl_addr      = '0;
		dl_dout      = 8'h00;
		cpu_rom_addr = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		nvram_we     = 1'b0;

		total_bytes = LOAD_CART_BYTES + N_CODES * 16;
		foreach (cart_size[i])
			total_bytes += cart_size[i];
		timeout_limit = total_bytes * (MAX_ROM_DELAY + 4) +
			2 * N_SECTORS * (MAX_SD_DELAY + MAX_SD_HOLD + 4) + N_CARTS * N_READS + 500;

		repeat (10) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		// First clock out of reset still shows the reset strobes
		idle_cycles(1);

		// Two full divider periods
		ce_window = 1'b1;
		idle_cycles(60);
		ce_window = 1'b0;
		if (n_cpu != 4) report_mismatch("ce_cpu pulse count", n_cpu, 4);
		if (n_vdp != 12) report_mismatch("ce_vdp pulse count", n_vdp, 12);
		if (n_pix != 6) report_mismatch("ce_pix pulse count", n_pix, 6);
		if (n_sp != 30) report_mismatch("ce_sp pulse count", n_sp, 30);
		end_test("clock enables");

		for (int c = 0; c < N_CARTS; c++) begin
			download_cart(cart_index[c], cart_size[c]);
			if (rom_addr_q.size() != cart_size[c]) begin
				report_error($sformatf("%0d ROM writes for a %0d-byte cartridge",
					rom_addr_q.size(), cart_size[c]));
			end else begin
				for (int i = 0; i < cart_size[c]; i++) begin
					if (rom_addr_q[i] !== ROM_ADDR_W'(i))
						report_mismatch("rom_wr_addr", rom_addr_q[i], i);
					if (rom_data_q[i] !== byte_at(DL_ADDR_W'(i)))
						report_mismatch("rom_wr_data", rom_data_q[i], byte_at(DL_ADDR_W'(i)));
				end
			end
			for (int r = 0; r < N_READS; r++) begin
				cpu_rom_addr = cpu_addrs[r];
				idle_cycles(1);
				if (rom_raddr !== expected_raddr(cpu_addrs[r], cart_size[c], cart_hdr[c]))
					report_mismatch("rom_raddr", rom_raddr,
						expected_raddr(cpu_addrs[r], cart_size[c], cart_hdr[c]));
			end
			gg_expect = cart_gg[c];
			if (gg_mode !== gg_expect)
				report_mismatch("gg_mode", gg_mode, gg_expect);
			end_test($sformatf("cartridge %0d (%0d bytes)", c, cart_size[c]));
		end

		for (int r = 0; r < N_CODES; r++) begin
			valid_count = 0;
			dl_index    = CODE_INDEX;
			dl_download = 1'b1;
			idle_cycles(1);
			for (int b = 0; b < 16; b++)
				send_byte(DL_ADDR_W'(b), cheat_bytes[r][b]);
			dl_download = 1'b0;
			idle_cycles(2);
			if (valid_count != 1)
				report_error($sformatf("code_valid pulsed %0d times for one record", valid_count));
			if (code !== cheat_expect[r])
				report_mismatch("code", code, cheat_expect[r]);
			if (gg_mode !== gg_expect)
				report_mismatch("gg_mode", gg_mode, gg_expect);
			end_test($sformatf("cheat record %0d", r));
		end

		// Writable image mounted while the cartridge arrives
		img_mounted = 1'b1;
		img_size_nz = 1'b1;
		sd_lba_q.delete();
		sd_kind_q.delete();
		download_cart(8'h00, LOAD_CART_BYTES);
		if (!bk_busy)
			report_error("no backup load started at the end of the download");
		while (bk_busy) begin
			if (!bk_loading)
				report_error("bk_loading low during a load");
			idle_cycles(1);
		end
		check_sectors(2'b10);
		end_test("automatic load");

		sd_lba_q.delete();
		sd_kind_q.delete();
		autosave = 1'b1;
		nvram_we = 1'b1;
		idle_cycles(1);
		nvram_we = 1'b0;
		idle_cycles(1);
		osd_open = 1'b1;
		waited   = 0;
		while (!bk_busy && waited < 8) begin
			idle_cycles(1);
			waited++;
		end
		if (!bk_busy)
			report_error("opening the menu did not start an autosave");
		while (bk_busy) begin
			if (bk_loading)
				report_error("bk_loading high during a save");
			idle_cycles(1);
		end
		check_sectors(2'b01);
		sd_lba_q.delete();
		sd_kind_q.delete();
		osd_open = 1'b0;
		idle_cycles(4);
		osd_open = 1'b1;                      // Nothing new to save this time
		idle_cycles(20);
		if (sd_lba_q.size() != 0 || bk_busy)
			report_error("second menu opening started a save without new writes");
		end_test("autosave");

		$display("Summary: %0d tests, %0d failing, %0d failed checks",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim.f
sms_cfg_pkg.sv
sms_types_pkg.sv
dl_if.sv
ce_gen.sv
cart_loader.sv
cheat_loader.sv
backup_sync.sv
sms_support.sv
tb_sms_support.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sms_support -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
